// File: Makefile
TOP = tb_mem_subsystem
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

obj_dir/V$(TOP): compile.f hw/*.sv hw/*.svh test/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/mem_arb_pkg.sv
hw/mem_req_slots.sv
hw/mem_rr_arbiter.sv
hw/mem_lrsc_table.sv
hw/mem_dual_ram.sv
hw/mem_subsystem.sv
test/mem_subsystem_chk.sv
test/tb_mem_subsystem.sv

// File: hw/mem_arb_pkg.sv
/*
 * arbitration types of the shared memory
 * requester index and one-bit-per-requester vector
 */
`include "mem_defs.svh"

package mem_arb_pkg;

    typedef logic [$clog2(`MEM_NPORTS)-1:0] port_idx_t;
    typedef logic [`MEM_NPORTS-1:0]         port_vec_t;

endpackage

// File: hw/mem_bus_pkg.sv
/*
 * request-side types of the shared memory
 * data words, word indices, byte strobes and the request opcode
 */
`include "mem_defs.svh"

package mem_bus_pkg;

    typedef logic [`MEM_DATA_W-1:0]  mem_word_t;
    typedef logic [`MEM_WORD_AW-1:0] mem_addr_t;  // word index, not byte address
    typedef logic [`MEM_STRB_W-1:0]  mem_strb_t;

    // LR reads and reserves, SC writes only while the reservation holds
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_LR    = 2'd2,
        OP_SC    = 2'd3
    } mem_op_e;

endpackage

// File: hw/mem_defs.svh
/*
 * shared memory subsystem dimensions
 * requester count, word and strobe widths, RAM depth
 */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// requesters sharing the data memory
`define MEM_NPORTS 4

`define MEM_DATA_W 32
`define MEM_STRB_W 4   // one strobe per byte

`define MEM_WORDS   1024
`define MEM_WORD_AW 10  // log2 of MEM_WORDS

`endif

// File: hw/mem_dual_ram.sv
/*
 * two-port word RAM with byte strobes
 * access on the lane stage, response one edge later to the lane's port
 */
`include "mem_defs.svh"

module mem_dual_ram import mem_bus_pkg::*, mem_arb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    lane_if.ram       lanes,
    output port_vec_t resp_valid_o,
    output mem_word_t resp_data_o [`MEM_NPORTS]
);
    mem_word_t  mem_q [`MEM_WORDS];
    mem_word_t  rd_q [2];
    logic [1:0] st_valid_q;
    port_idx_t  st_port_q [2];
    mem_op_e    st_op_q [2];
    logic [1:0] st_ok_q;
    logic [1:0] wr_en;
    mem_word_t  resp_word [2];

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            wr_en[l] = lanes.valid[l] && (lanes.op[l] == OP_STORE ||
                       (lanes.op[l] == OP_SC && lanes.sc_ok[l]));
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (wr_en[l] && lanes.strb[l][b]) begin
                    mem_q[lanes.addr[l]][8*b +: 8] <= lanes.wdata[l][8*b +: 8];
                end
            end
            if (lanes.valid[l] && (lanes.op[l] == OP_LOAD || lanes.op[l] == OP_LR)) begin
                rd_q[l] <= mem_q[lanes.addr[l]];
            end
            st_port_q[l] <= lanes.port[l];
            st_op_q[l]   <= lanes.op[l];
            st_ok_q[l]   <= lanes.sc_ok[l];
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            case (st_op_q[l])
                OP_STORE: resp_word[l] = '0;
                OP_SC:    resp_word[l] = mem_word_t'(!st_ok_q[l]);  // 0 on success
                default:  resp_word[l] = rd_q[l];
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_valid_q   <= '0;
            resp_valid_o <= '0;
        end else begin
            st_valid_q <= lanes.valid;
            for (int p = 0; p < `MEM_NPORTS; p++) begin
                resp_valid_o[p] <= (st_valid_q[0] && st_port_q[0] == port_idx_t'(p)) ||
                                   (st_valid_q[1] && st_port_q[1] == port_idx_t'(p));
            end
        end
    end

    // lanes never carry the same port, at most one write per port
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (st_valid_q[l]) begin
                resp_data_o[st_port_q[l]] <= resp_word[l];
            end
        end
    end

endmodule

// File: hw/mem_lrsc_table.sv
/*
 * load-reserved / store-conditional reservation table
 * one entry per requester, SC verdict per lane,
 * stores to a reserved word drop every reservation on it
 */
`include "mem_defs.svh"

module mem_lrsc_table import mem_bus_pkg::*, mem_arb_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    lane_if.lrsc lanes
);
    port_vec_t  rsv_valid_q;
    mem_addr_t  rsv_word_q [`MEM_NPORTS];
    logic [1:0] kill;   // lane writes its word this cycle

    // own entry valid and on the same word
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            lanes.sc_ok[l] = lanes.valid[l] && lanes.op[l] == OP_SC &&
                             rsv_valid_q[lanes.port[l]] &&
                             rsv_word_q[lanes.port[l]] == lanes.addr[l];
            kill[l] = lanes.valid[l] &&
                      (lanes.op[l] == OP_STORE || lanes.sc_ok[l]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsv_valid_q <= '0;
        end else begin
            for (int p = 0; p < `MEM_NPORTS; p++) begin
                for (int l = 0; l < 2; l++) begin
                    if (kill[l] && rsv_word_q[p] == lanes.addr[l]) begin
                        rsv_valid_q[p] <= 1'b0;
                    end
                end
            end
            // lanes carry different words, so a new LR never collides with a kill
            for (int l = 0; l < 2; l++) begin
                if (lanes.valid[l] && lanes.op[l] == OP_LR) begin
                    rsv_valid_q[lanes.port[l]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (lanes.valid[l] && lanes.op[l] == OP_LR) begin
                rsv_word_q[lanes.port[l]] <= lanes.addr[l];
            end
        end
    end

endmodule

// File: hw/mem_req_slots.sv
/*
 * request holding slots, one per requester
 * valid/ready acceptance, ready held low until the response leaves
 * also declares slot_if towards the arbiter
 */
`include "mem_defs.svh"

interface slot_if import mem_bus_pkg::*, mem_arb_pkg::*; ();
    port_vec_t pending;                 // slot holds an ungranted request
    mem_op_e   op    [`MEM_NPORTS];
    mem_addr_t addr  [`MEM_NPORTS];
    mem_word_t wdata [`MEM_NPORTS];
    mem_strb_t strb  [`MEM_NPORTS];
    port_vec_t served;                  // one-cycle grant pulse

    modport slots (output pending, op, addr, wdata, strb, input served);
    modport arb   (input pending, op, addr, wdata, strb, output served);
endinterface

module mem_req_slots import mem_bus_pkg::*, mem_arb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  port_vec_t req_valid_i,
    input  mem_op_e   req_op_i    [`MEM_NPORTS],
    input  mem_addr_t req_addr_i  [`MEM_NPORTS],
    input  mem_word_t req_wdata_i [`MEM_NPORTS],
    input  mem_strb_t req_strb_i  [`MEM_NPORTS],
    output port_vec_t req_ready_o,
    slot_if.slots     slots
);
    port_vec_t busy_q;     // accepted, response not yet out
    port_vec_t pend_q;
    port_vec_t srv_d1_q;   // grant seen one edge ago
    port_vec_t srv_d2_q;   // response goes out on the next edge
    port_vec_t accept;

    assign accept        = req_valid_i & ~busy_q;
    assign req_ready_o   = ~busy_q;
    assign slots.pending = pend_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= '0;
            pend_q   <= '0;
            srv_d1_q <= '0;
            srv_d2_q <= '0;
        end else begin
            busy_q   <= (busy_q | accept) & ~srv_d2_q;
            pend_q   <= (pend_q | accept) & ~slots.served;
            srv_d1_q <= slots.served;  // lane stage
            srv_d2_q <= srv_d1_q;      // ram stage
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            if (accept[p]) begin
                slots.op[p]    <= req_op_i[p];
                slots.addr[p]  <= req_addr_i[p];
                slots.wdata[p] <= req_wdata_i[p];
                slots.strb[p]  <= req_strb_i[p];
            end
        end
    end

endmodule

// File: hw/mem_rr_arbiter.sv
/*
 * two-lane round-robin arbiter
 * grants up to two pending slots per cycle to different words
 * also declares lane_if, the registered lanes towards table and RAM
 */
`include "mem_defs.svh"

interface lane_if import mem_bus_pkg::*, mem_arb_pkg::*; ();
    // index 0 is lane a, index 1 is lane b
    logic [1:0] valid;
    port_idx_t  port  [2];
    mem_op_e    op    [2];
    mem_addr_t  addr  [2];
    mem_word_t  wdata [2];
    mem_strb_t  strb  [2];
    logic [1:0] sc_ok;   // reservation still held, for SC only

    modport arb  (output valid, port, op, addr, wdata, strb);
    modport lrsc (input valid, port, op, addr, wdata, strb, output sc_ok);
    modport ram  (input valid, port, op, addr, wdata, strb, sc_ok);
endinterface

module mem_rr_arbiter import mem_bus_pkg::*, mem_arb_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    slot_if.arb  slots,
    lane_if.arb  lanes
);
    port_idx_t  ptr_q;
    port_idx_t  sel [2];
    logic [1:0] hit;
    port_idx_t  cand_a;
    port_idx_t  cand_b;
    mem_addr_t  word_a;

    function automatic port_idx_t step(port_idx_t p, int k);
        return port_idx_t'((int'(p) + k) % `MEM_NPORTS);
    endfunction

    // lane a: first pending port at or after the pointer
    always_comb begin
        hit[0] = 1'b0;
        sel[0] = ptr_q;
        for (int k = 0; k < `MEM_NPORTS; k++) begin
            cand_a = step(ptr_q, k);
            if (!hit[0] && slots.pending[cand_a]) begin
                hit[0] = 1'b1;
                sel[0] = cand_a;
            end
        end
    end

    assign word_a = slots.addr[sel[0]];

    // lane b: next pending port after lane a, other word only
    always_comb begin
        hit[1] = 1'b0;
        sel[1] = sel[0];
        for (int k = 1; k < `MEM_NPORTS; k++) begin
            cand_b = step(sel[0], k);
            if (hit[0] && !hit[1] && slots.pending[cand_b] &&
                slots.addr[cand_b] != word_a) begin
                hit[1] = 1'b1;
                sel[1] = cand_b;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            slots.served[p] = (hit[0] && sel[0] == port_idx_t'(p)) ||
                              (hit[1] && sel[1] == port_idx_t'(p));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lanes.valid <= '0;
            ptr_q       <= '0;
        end else begin
            lanes.valid <= hit;
            if (hit[1]) begin
                ptr_q <= step(sel[1], 1);  // past the last port granted
            end else if (hit[0]) begin
                ptr_q <= step(sel[0], 1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            lanes.port[l]  <= sel[l];
            lanes.op[l]    <= slots.op[sel[l]];
            lanes.addr[l]  <= slots.addr[sel[l]];
            lanes.wdata[l] <= slots.wdata[sel[l]];
            lanes.strb[l]  <= slots.strb[sel[l]];
        end
    end

endmodule

// File: hw/mem_subsystem.sv
/*
 * shared data memory for four requesters
 * request slots, two-lane round-robin arbiter, LR/SC table, dual-port RAM
 */
`include "mem_defs.svh"

module mem_subsystem import mem_bus_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`MEM_NPORTS-1:0] req_valid_i,
    input  mem_op_e                req_op_i    [`MEM_NPORTS],
    input  mem_addr_t              req_addr_i  [`MEM_NPORTS],
    input  mem_word_t              req_wdata_i [`MEM_NPORTS],
    input  mem_strb_t              req_strb_i  [`MEM_NPORTS],
    output logic [`MEM_NPORTS-1:0] req_ready_o,
    output logic [`MEM_NPORTS-1:0] resp_valid_o,
    output mem_word_t              resp_data_o [`MEM_NPORTS]
);
    slot_if u_slot_if ();
    lane_if u_lane_if ();

    // ready comes back on its own when the response leaves
    mem_req_slots u_slots (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_strb_i  (req_strb_i),
        .req_ready_o (req_ready_o),
        .slots       (u_slot_if.slots)
    );

    mem_rr_arbiter u_arb (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .slots   (u_slot_if.arb),
        .lanes   (u_lane_if.arb)
    );

    mem_lrsc_table u_lrsc (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .lanes   (u_lane_if.lrsc)
    );

    mem_dual_ram u_ram (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lanes        (u_lane_if.ram),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o)
    );

endmodule

// File: test/mem_subsystem_chk.sv
/*
 * bound checks on the shared memory handshakes
 * lane word conflicts, stray responses, ready while a slot is full
 */
`include "mem_defs.svh"

module mem_subsystem_chk import mem_bus_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic [`MEM_NPORTS-1:0] req_valid_i,
    input logic [`MEM_NPORTS-1:0] ready_i,
    input logic [`MEM_NPORTS-1:0] resp_valid_i,
    input logic [1:0]             lane_valid_i,
    input mem_addr_t              lane_addr_a_i,
    input mem_addr_t              lane_addr_b_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`MEM_NPORTS-1:0] open_q;  // accepted, not yet answered

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            open_q <= '0;
        end else begin
            open_q <= (open_q & ~resp_valid_i) | (req_valid_i & ready_i);
        end
    end

    lanes_differ: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        &lane_valid_i |-> lane_addr_a_i != lane_addr_b_i)
        else $error("both lanes carry word %0d", lane_addr_a_i);

    for (genvar p = 0; p < `MEM_NPORTS; p++) begin : g_port
        resp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            resp_valid_i[p] |-> open_q[p])
            else $error("response on port %0d with no request outstanding", p);

        // response cycle is exempt, ready returns together with it
        ready_low_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            open_q[p] && !resp_valid_i[p] |-> !ready_i[p])
            else $error("ready high on port %0d while its slot is full", p);
    end

endmodule

// File: test/tb_mem_subsystem.sv
/*
 * testbench for the shared data memory
 * directed tests against a reference word array with LR/SC reservations
 */
`include "mem_defs.svh"

module tb_mem_subsystem import mem_bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int READY_TIMEOUT = 20;  // cycles
    localparam int RESP_TIMEOUT  = 60;

    logic                   clk_i;
    logic                   rst_n_i;
    logic [`MEM_NPORTS-1:0] req_valid_i;
    mem_op_e                req_op_i    [`MEM_NPORTS];
    mem_addr_t              req_addr_i  [`MEM_NPORTS];
    mem_word_t              req_wdata_i [`MEM_NPORTS];
    mem_strb_t              req_strb_i  [`MEM_NPORTS];
    logic [`MEM_NPORTS-1:0] req_ready_o;
    logic [`MEM_NPORTS-1:0] resp_valid_o;
    mem_word_t              resp_data_o [`MEM_NPORTS];

    mem_word_t ref_mem   [`MEM_WORDS];  // reference memory
    logic      rsv_valid [`MEM_NPORTS];
    mem_addr_t rsv_word  [`MEM_NPORTS];
    mem_op_e   b_op      [`MEM_NPORTS];  // next batch, one entry per port
    mem_addr_t b_addr    [`MEM_NPORTS];
    mem_word_t b_wdata   [`MEM_NPORTS];
    mem_strb_t b_strb    [`MEM_NPORTS];
    mem_word_t got       [`MEM_NPORTS];
    int        errors;
    int        checks;
    int        tests;

    mem_subsystem UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o)
    );

    bind mem_subsystem mem_subsystem_chk u_chk (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .ready_i       (req_ready_o),
        .resp_valid_i  (resp_valid_o),
        .lane_valid_i  (u_lane_if.valid),
        .lane_addr_a_i (u_lane_if.addr[0]),
        .lane_addr_b_i (u_lane_if.addr[1])
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // applies one request to the model and returns the expected response
    function automatic mem_word_t model_access(int p, mem_op_e op, mem_addr_t a,
                                               mem_word_t wd, mem_strb_t st);
        mem_word_t rsp;
        logic      held;
        rsp  = '0;
        held = rsv_valid[p] && rsv_word[p] == a;
        if (op == OP_LOAD || op == OP_LR) begin
            rsp = ref_mem[a];
        end
        if (op == OP_LR) begin
            rsv_valid[p] = 1'b1;
            rsv_word[p]  = a;
        end
        if (op == OP_STORE || (op == OP_SC && held)) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (st[b]) ref_mem[a][8*b +: 8] = wd[8*b +: 8];
            end
            for (int q = 0; q < `MEM_NPORTS; q++) begin
                if (rsv_word[q] == a) rsv_valid[q] = 1'b0;  // every reservation on it
            end
        end
        if (op == OP_SC) begin
            rsp = held ? '0 : mem_word_t'(1);
        end
        return rsp;
    endfunction

    task automatic set_req(input int p, input mem_op_e op, input mem_addr_t a,
                           input mem_word_t wd, input mem_strb_t st);
        b_op[p]    = op;
        b_addr[p]  = a;
        b_wdata[p] = wd;
        b_strb[p]  = st;
    endtask

    task automatic send_batch(input logic [`MEM_NPORTS-1:0] mask);
        int cycles;
        cycles = 0;
        while ((req_ready_o & mask) != mask && cycles < READY_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert ((req_ready_o & mask) == mask) else begin
            $display("ready never came back on ports %b", mask & ~req_ready_o);
            errors++;
        end
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            if (mask[p]) begin
                req_op_i[p]    <= b_op[p];
                req_addr_i[p]  <= b_addr[p];
                req_wdata_i[p] <= b_wdata[p];
                req_strb_i[p]  <= b_strb[p];
            end
        end
        req_valid_i <= mask;
        @(posedge clk_i);
        req_valid_i <= '0;
    endtask

    // collects one response per masked port, then watches a few idle cycles
    task automatic wait_responses(input logic [`MEM_NPORTS-1:0] mask);
        logic [`MEM_NPORTS-1:0] seen;
        int                     cycles;
        int                     tail;
        seen   = '0;
        cycles = 0;
        tail   = 0;
        while (cycles < RESP_TIMEOUT && !(seen == mask && tail == 4)) begin
            @(posedge clk_i);
            cycles++;
            if (seen == mask) tail++;
            for (int p = 0; p < `MEM_NPORTS; p++) begin
                if (resp_valid_o[p]) begin
                    assert (mask[p] && !seen[p]) else begin
                        $display("port %0d answered with no request outstanding", p);
                        errors++;
                    end
                    seen[p] = 1'b1;
                    got[p]  = resp_data_o[p];
                end
            end
        end
        assert (seen == mask) else begin
            $display("timeout waiting for responses on ports %b", mask & ~seen);
            errors++;
        end
    endtask

    task automatic run_batch(input logic [`MEM_NPORTS-1:0] mask);
        mem_word_t exp [`MEM_NPORTS];
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            if (mask[p]) exp[p] = model_access(p, b_op[p], b_addr[p], b_wdata[p], b_strb[p]);
        end
        send_batch(mask);
        wait_responses(mask);
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            if (mask[p]) begin
                checks++;
                assert (got[p] === exp[p]) else begin
                    $display("FAILED %0t: port %0d %s word %0d returned %h, expected %h",
                             $time, p, b_op[p].name(), b_addr[p], got[p], exp[p]);
                    errors++;
                end
            end
        end
    endtask

    task automatic expect_word(input int p, input mem_word_t exp, input string what);
        checks++;
        assert (got[p] === exp) else begin
            $display("FAILED %0t: %s on port %0d gave %h, expected %h",
                     $time, what, p, got[p], exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("%s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        checks++;
        assert (req_ready_o == '1 && resp_valid_o == '0) else begin
            $display("FAILED %0t: after reset ready %b, resp_valid %b",
                     $time, req_ready_o, resp_valid_o);
            errors++;
        end
        finish_test("reset state", e0);
    endtask

    task automatic strobe_merge();
        int e0;
        e0 = errors;
        set_req(2, OP_STORE, 10'd5, 32'h1122_3344, 4'hf);
        run_batch(4'b0100);
        set_req(2, OP_STORE, 10'd5, 32'haabb_ccdd, 4'b0101);  // bytes 0 and 2
        run_batch(4'b0100);
        set_req(2, OP_LOAD, 10'd5, '0, '0);
        run_batch(4'b0100);
        expect_word(2, 32'h11bb_33dd, "merged load");
        finish_test("byte strobes", e0);
    endtask

    task automatic concurrent_traffic();
        mem_addr_t words [`MEM_NPORTS];
        int        e0;
        e0 = errors;
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            words[p] = mem_addr_t'(64 + 16 * p + $urandom_range(15));  // distinct words
            set_req(p, OP_STORE, words[p], $urandom(), 4'hf);
        end
        run_batch('1);
        repeat (6) begin
            for (int p = 0; p < `MEM_NPORTS; p++) begin
                set_req(p, ($urandom_range(1) == 0) ? OP_LOAD : OP_STORE, words[p],
                        $urandom(), mem_strb_t'($urandom_range(15, 1)));
            end
            run_batch('1);
        end
        finish_test("concurrent traffic", e0);
    endtask

    task automatic lr_sc_success();
        int e0;
        e0 = errors;
        set_req(1, OP_STORE, 10'd300, 32'h0bad_f00d, 4'hf);
        run_batch(4'b0010);
        set_req(1, OP_LR, 10'd300, '0, '0);
        run_batch(4'b0010);
        set_req(1, OP_SC, 10'd300, 32'h1234_5678, 4'hf);
        run_batch(4'b0010);
        expect_word(1, 32'd0, "SC after LR");
        set_req(1, OP_LOAD, 10'd300, '0, '0);
        run_batch(4'b0010);
        expect_word(1, 32'h1234_5678, "read back after SC");
        finish_test("LR/SC success", e0);
    endtask

    task automatic sc_after_store();
        int e0;
        e0 = errors;
        set_req(0, OP_STORE, 10'd400, 32'h0000_0400, 4'hf);
        run_batch(4'b0001);
        set_req(0, OP_LR, 10'd400, '0, '0);
        run_batch(4'b0001);
        set_req(1, OP_STORE, 10'd400, 32'hcafe_0001, 4'hf);  // breaks port 0's reservation
        run_batch(4'b0010);
        set_req(0, OP_SC, 10'd400, 32'hdead_0000, 4'hf);
        run_batch(4'b0001);
        expect_word(0, 32'd1, "SC after foreign store");
        set_req(2, OP_LOAD, 10'd400, '0, '0);
        run_batch(4'b0100);
        expect_word(2, 32'hcafe_0001, "word after failed SC");
        finish_test("failed SC", e0);
    endtask

    task automatic same_word_contention();
        int e0;
        e0 = errors;
        set_req(3, OP_STORE, 10'd500, 32'h5a5a_0500, 4'hf);
        run_batch(4'b1000);
        repeat (6) begin
            for (int p = 0; p < `MEM_NPORTS; p++) begin
                set_req(p, OP_LOAD, 10'd500, '0, '0);  // one grant per cycle on one word
            end
            run_batch('1);
        end
        finish_test("same word contention", e0);
    endtask

    initial begin
        void'($urandom(32'hafeb));
        errors      = 0;
        checks      = 0;
        tests       = 0;
        rst_n_i     = 1'b0;
        req_valid_i = '0;
        for (int p = 0; p < `MEM_NPORTS; p++) begin
            req_op_i[p]    = OP_LOAD;
            req_addr_i[p]  = '0;
            req_wdata_i[p] = '0;
            req_strb_i[p]  = '0;
            rsv_valid[p]   = 1'b0;
            rsv_word[p]    = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        check_reset_state();
        strobe_merge();
        concurrent_traffic();
        lr_sc_success();
        sc_after_store();
        same_word_contention();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
